//--- hdl/fp_cmp_pkg.sv
/*
  FP compare/classify package
  Operation codes, FCLASS bit positions and canonical NaN patterns
*/
package fp_cmp_pkg;

  // Operation select, 3'd6 and 3'd7 reserved
  typedef enum logic [2:0] {
    OP_FEQ    = 3'd0,
    OP_FLT    = 3'd1,
    OP_FLE    = 3'd2,
    OP_FMIN   = 3'd3,
    OP_FMAX   = 3'd4,
    OP_FCLASS = 3'd5
  } fp_op_e;

  // Unpacked field widths, sized for double
  localparam int EXP_W = 11;
  localparam int MAN_W = 52;

  localparam int FCLASS_W = 10;  // RISC-V FCLASS mask width

  // FCLASS bit positions
  localparam int CLS_NEG_INF  = 0;
  localparam int CLS_NEG_NORM = 1;
  localparam int CLS_NEG_SUB  = 2;
  localparam int CLS_NEG_ZERO = 3;
  localparam int CLS_POS_ZERO = 4;
  localparam int CLS_POS_SUB  = 5;
  localparam int CLS_POS_NORM = 6;
  localparam int CLS_POS_INF  = 7;
  localparam int CLS_SNAN     = 8;
  localparam int CLS_QNAN     = 9;

  // Canonical quiet NaNs
  localparam logic [31:0] CANON_NAN_S = 32'h7FC0_0000;
  localparam logic [63:0] CANON_NAN_D = 64'h7FF8_0000_0000_0000;

endpackage

//--- hdl/fp_unpack.sv
/*
  FP operand unpacker
  Splits one operand into sign/exponent/mantissa and class bits,
  checking the NaN box of single-precision values when FLEN is 64
*/
`timescale 1ns/1ps

module fp_unpack import fp_cmp_pkg::*; #(
  parameter int FLEN = 64  // 32 or 64
) (
  input  logic [FLEN-1:0]  operand,
  input  logic             fmt,      // 0 single, 1 double
  output logic             sign,
  output logic [EXP_W-1:0] exp,      // Zero-extended for single
  output logic [MAN_W-1:0] man,      // Zero-extended for single
  output logic             is_nan,
  output logic             is_snan,
  output logic             is_inf,
  output logic             is_zero,
  output logic             is_sub
);

  logic [63:0]      op64;      // Operand widened to double width
  logic             dbl;       // Double format in effect
  logic             boxed;     // Upper half all ones, or no upper half
  logic [EXP_W-1:0] exp_ones;  // All-ones exponent of the format
  logic             quiet;     // Mantissa MSB of the format
  logic             exp_max;
  logic             man_nz;

  assign op64 = 64'(operand);
  assign dbl  = (FLEN == 64) ? fmt : 1'b0;  // FLEN 32 has single only

  // Only FLEN 64 carries a box to check
  assign boxed = (FLEN == 32) || (&op64[63:32]);

  // Field extraction per format
  always_comb begin
    if (dbl) begin
      sign = op64[63];
      exp  = op64[62:52];
      man  = op64[51:0];
    end else if (boxed) begin
      sign = op64[31];
      exp  = {3'b000, op64[30:23]};
      man  = {29'b0, op64[22:0]};
    end else begin
      // Broken box reads as canonical qNaN
      sign = CANON_NAN_S[31];
      exp  = {3'b000, CANON_NAN_S[30:23]};
      man  = {29'b0, CANON_NAN_S[22:0]};
    end
  end

  assign exp_ones = dbl ? 11'h7FF : 11'h0FF;
  assign quiet    = dbl ? man[51] : man[22];  // Set for quiet NaN

  assign exp_max = (exp == exp_ones);
  assign man_nz  = |man;

  // Class bits
  assign is_nan  = exp_max && man_nz;
  assign is_snan = is_nan && !quiet;       // Signaling when MSB clear
  assign is_inf  = exp_max && !man_nz;
  assign is_zero = (exp == '0) && !man_nz;
  assign is_sub  = (exp == '0) && man_nz;  // Denormal

endmodule

//--- hdl/fp_compare.sv
/*
  FP comparator
  IEEE 754 equal and less-than relations plus NaN indications
  for two unpacked operands
*/
`timescale 1ns/1ps

module fp_compare import fp_cmp_pkg::*; (
  input  logic             sign_a,
  input  logic [EXP_W-1:0] exp_a,
  input  logic [MAN_W-1:0] man_a,
  input  logic             is_nan_a,
  input  logic             is_snan_a,
  input  logic             is_zero_a,
  input  logic             sign_b,
  input  logic [EXP_W-1:0] exp_b,
  input  logic [MAN_W-1:0] man_b,
  input  logic             is_nan_b,
  input  logic             is_snan_b,
  input  logic             is_zero_b,
  output logic             eq,
  output logic             lt,
  output logic             any_nan,   // Either operand NaN
  output logic             any_snan   // Either operand signaling NaN
);

  logic both_zero;
  logic signs_differ;
  logic mag_lt;  // |a| < |b|
  logic mag_eq;  // |a| == |b|
  logic raw_eq;
  logic raw_lt;

  assign any_nan  = is_nan_a || is_nan_b;
  assign any_snan = is_snan_a || is_snan_b;

  assign both_zero    = is_zero_a && is_zero_b;  // +0 and -0 compare equal
  assign signs_differ = sign_a ^ sign_b;

  // Magnitude order, exponent first then mantissa
  assign mag_lt = (exp_a < exp_b) || ((exp_a == exp_b) && (man_a < man_b));
  assign mag_eq = (exp_a == exp_b) && (man_a == man_b);

  assign raw_eq = both_zero || (!signs_differ && mag_eq);

  // Ordering ignoring NaNs
  always_comb begin
    if (both_zero)
      raw_lt = 1'b0;                 // Zeros never less
    else if (signs_differ)
      raw_lt = sign_a;               // Negative side is smaller
    else if (!sign_a)
      raw_lt = mag_lt;               // Both positive
    else
      raw_lt = !mag_lt && !mag_eq;   // Both negative, reversed
  end

  // Unordered when a NaN is present
  assign eq = raw_eq && !any_nan;
  assign lt = raw_lt && !any_nan;

endmodule

//--- hdl/fp_minmax.sv
/*
  FP min/max selector
  FMIN/FMAX with minimumNumber/maximumNumber NaN handling,
  signed zero ordering and the canonical NaN of the format
*/
`timescale 1ns/1ps

module fp_minmax import fp_cmp_pkg::*; #(
  parameter int FLEN = 64  // 32 or 64
) (
  input  logic [FLEN-1:0] operand_a,
  input  logic [FLEN-1:0] operand_b,
  input  logic            fmt,        // 0 single, 1 double
  input  logic            sel_max,    // 1 for FMAX
  input  logic            lt,         // a < b from the comparator
  input  logic            sign_a,
  input  logic            sign_b,
  input  logic            is_nan_a,
  input  logic            is_nan_b,
  input  logic            is_zero_a,
  input  logic            is_zero_b,
  output logic [FLEN-1:0] value
);

  logic        dbl;
  logic [63:0] canon64;     // Canonical NaN, single boxed with ones
  logic        mixed_zero;  // +0 against -0
  logic        pick_a;

  assign dbl = (FLEN == 64) && fmt;

  // Truncates to CANON_NAN_S when FLEN is 32
  assign canon64 = dbl ? CANON_NAN_D : {32'hFFFF_FFFF, CANON_NAN_S};

  assign mixed_zero = is_zero_a && is_zero_b && (sign_a != sign_b);

  // Operand choice for ordered inputs
  always_comb begin
    if (mixed_zero)
      pick_a = sel_max ? !sign_a : sign_a;  // -0 is the min, +0 the max
    else
      pick_a = sel_max ? !lt : lt;
  end

  always_comb begin
    if (is_nan_a && is_nan_b)
      value = canon64[FLEN-1:0];
    else if (is_nan_a)
      value = operand_b;  // NaN loses to a number
    else if (is_nan_b)
      value = operand_a;
    else if (pick_a)
      value = operand_a;
    else
      value = operand_b;
  end

  // Returned operands are already boxed when they are not NaN

endmodule

//--- hdl/fp_classify.sv
/*
  FCLASS mask builder
  One-hot ten-bit RISC-V class mask from unpacked class bits
*/
`timescale 1ns/1ps

module fp_classify import fp_cmp_pkg::*; (
  input  logic                sign,
  input  logic                is_inf,
  input  logic                is_zero,
  input  logic                is_sub,
  input  logic                is_nan,
  input  logic                is_snan,
  output logic [FCLASS_W-1:0] mask
);

  logic is_norm;  // None of the special classes

  assign is_norm = !(is_inf || is_zero || is_sub || is_nan);

  always_comb begin
    mask = '0;
    if (is_nan) begin
      // NaN sign is ignored
      mask[CLS_SNAN] = is_snan;
      mask[CLS_QNAN] = !is_snan;
    end else begin
      mask[CLS_NEG_INF]  = sign && is_inf;
      mask[CLS_NEG_NORM] = sign && is_norm;
      mask[CLS_NEG_SUB]  = sign && is_sub;
      mask[CLS_NEG_ZERO] = sign && is_zero;
      mask[CLS_POS_ZERO] = !sign && is_zero;
      mask[CLS_POS_SUB]  = !sign && is_sub;
      mask[CLS_POS_NORM] = !sign && is_norm;
      mask[CLS_POS_INF]  = !sign && is_inf;
    end
  end

endmodule

//--- hdl/fp_cmp_unit.sv
/*
  FP compare/classify unit
  FEQ, FLT, FLE, FMIN, FMAX and FCLASS for F and D formats,
  one registered stage with the invalid flag
*/
`timescale 1ns/1ps

module fp_cmp_unit import fp_cmp_pkg::*; #(
  parameter int FLEN = 64  // 32 or 64
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            in_valid,   // One-cycle strobe
  input  fp_op_e          op,
  input  logic            fmt,        // 0 single, 1 double
  input  logic [FLEN-1:0] operand_a,
  input  logic [FLEN-1:0] operand_b,
  output logic            out_valid,
  output logic [FLEN-1:0] result,
  output logic            flag_nv     // Invalid operation
);

  // Unpacked operand A
  logic             sign_a, is_nan_a, is_snan_a, is_inf_a, is_zero_a, is_sub_a;
  logic [EXP_W-1:0] exp_a;
  logic [MAN_W-1:0] man_a;
  // Unpacked operand B, inf/sub not needed
  logic             sign_b, is_nan_b, is_snan_b, is_zero_b;
  logic [EXP_W-1:0] exp_b;
  logic [MAN_W-1:0] man_b;

  logic                eq, lt, any_nan, any_snan;
  logic                sel_max;
  logic [FLEN-1:0]     mm_value;   // FMIN/FMAX result
  logic [FCLASS_W-1:0] cls_mask;
  logic [FLEN-1:0]     res_d;
  logic                nv_d;

  fp_unpack #(.FLEN(FLEN)) unpack_a (
    .operand(operand_a), .fmt(fmt),
    .sign(sign_a), .exp(exp_a), .man(man_a),
    .is_nan(is_nan_a), .is_snan(is_snan_a), .is_inf(is_inf_a),
    .is_zero(is_zero_a), .is_sub(is_sub_a)
  );

  fp_unpack #(.FLEN(FLEN)) unpack_b (
    .operand(operand_b), .fmt(fmt),
    .sign(sign_b), .exp(exp_b), .man(man_b),
    .is_nan(is_nan_b), .is_snan(is_snan_b), .is_inf(),
    .is_zero(is_zero_b), .is_sub()
  );

  fp_compare compare_i (
    .sign_a(sign_a), .exp_a(exp_a), .man_a(man_a),
    .is_nan_a(is_nan_a), .is_snan_a(is_snan_a), .is_zero_a(is_zero_a),
    .sign_b(sign_b), .exp_b(exp_b), .man_b(man_b),
    .is_nan_b(is_nan_b), .is_snan_b(is_snan_b), .is_zero_b(is_zero_b),
    .eq(eq), .lt(lt), .any_nan(any_nan), .any_snan(any_snan)
  );

  assign sel_max = (op == OP_FMAX);

  fp_minmax #(.FLEN(FLEN)) minmax_i (
    .operand_a(operand_a), .operand_b(operand_b), .fmt(fmt),
    .sel_max(sel_max), .lt(lt), .sign_a(sign_a), .sign_b(sign_b),
    .is_nan_a(is_nan_a), .is_nan_b(is_nan_b),
    .is_zero_a(is_zero_a), .is_zero_b(is_zero_b),
    .value(mm_value)
  );

  fp_classify classify_i (
    .sign(sign_a), .is_inf(is_inf_a), .is_zero(is_zero_a),
    .is_sub(is_sub_a), .is_nan(is_nan_a), .is_snan(is_snan_a),
    .mask(cls_mask)
  );

  // Result select and NV rule
  always_comb begin
    res_d = '0;
    nv_d  = 1'b0;
    case (op)
      OP_FEQ:    begin res_d = FLEN'(eq);        nv_d = any_snan; end  // Quiet compare
      OP_FLT:    begin res_d = FLEN'(lt);        nv_d = any_nan;  end  // Signaling compare
      OP_FLE:    begin res_d = FLEN'(lt || eq);  nv_d = any_nan;  end
      OP_FMIN,
      OP_FMAX:   begin res_d = mm_value;         nv_d = any_snan; end
      OP_FCLASS: res_d = FLEN'(cls_mask);                              // Never invalid
      default:   ;                                                     // Reserved codes
    endcase
  end

  // Output stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
      flag_nv   <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin  // Hold until the next operation
        result  <= res_d;
        flag_nv <= nv_d;
      end
    end
  end

endmodule

//--- testbench/fp_cmp_unit_sva.sv
/*
  Timing and output checks for the FP compare/classify unit
*/
`timescale 1ns/1ps

module fp_cmp_unit_sva import fp_cmp_pkg::*; #(
  parameter int FLEN = 64
) (
  input logic            clk,
  input logic            arst_n,
  input logic            in_valid,
  input fp_op_e          op,
  input logic            out_valid,
  input logic [FLEN-1:0] result,
  input logic            flag_nv
);

  // Output strobe is the input strobe one cycle later
  a_valid_follow: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |=> out_valid) else $error("out_valid missing after in_valid");
  a_valid_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    !in_valid |=> !out_valid) else $error("out_valid without in_valid");

  a_reset_low: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else $error("out_valid high during reset");

  // FCLASS never raises NV and sets one class bit
  a_fclass_nv: assert property (@(posedge clk) disable iff (!arst_n)
    (in_valid && op == OP_FCLASS) |=> !flag_nv) else $error("NV set by FCLASS");
  a_fclass_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    (in_valid && op == OP_FCLASS) |=> $onehot(result)) else $error("FCLASS mask not one-hot");

endmodule

bind fp_cmp_unit fp_cmp_unit_sva #(.FLEN(FLEN)) fp_cmp_unit_sva_i (
  .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .op(op),
  .out_valid(out_valid), .result(result), .flag_nv(flag_nv)
);

//--- testbench/tb_fp_cmp_ref.svh
/*
  Reference model for the FP compare/classify unit
  Expected result and NV flag computed from raw operand bits
*/
`ifndef TB_FP_CMP_REF_SVH
`define TB_FP_CMP_REF_SVH

// Single operand without a valid box stands in as the canonical qNaN
function automatic logic [63:0] unbox(input logic f, input logic [63:0] x);
  if (!f && x[63:32] != 32'hFFFF_FFFF)
    return {32'hFFFF_FFFF, CANON_NAN_S};
  return x;
endfunction

function automatic logic [62:0] magnitude(input logic f, input logic [63:0] x);
  return f ? x[62:0] : {32'b0, x[30:0]};  // Sign stripped
endfunction

function automatic logic sign_of(input logic f, input logic [63:0] x);
  return f ? x[63] : x[31];
endfunction

// Magnitude of infinity, anything above is NaN
function automatic logic [62:0] inf_mag(input logic f);
  return f ? 63'h7FF0_0000_0000_0000 : 63'h7F80_0000;
endfunction

// Smallest normal magnitude
function automatic logic [62:0] norm_min(input logic f);
  return f ? 63'h0010_0000_0000_0000 : 63'h0080_0000;
endfunction

function automatic logic nan_val(input logic f, input logic [63:0] x);
  return magnitude(f, x) > inf_mag(f);
endfunction

function automatic logic snan_val(input logic f, input logic [63:0] x);
  logic quiet;
  quiet = f ? x[51] : x[22];  // Quiet bit is the mantissa MSB
  return nan_val(f, x) && !quiet;
endfunction

// Signed key with the numeric order of non-NaN values, both zeros give 0
function automatic logic signed [64:0] order_key(input logic f, input logic [63:0] x);
  logic signed [64:0] m;
  m = $signed({2'b00, magnitude(f, x)});
  return sign_of(f, x) ? -m : m;
endfunction

function automatic logic [63:0] class_mask(input logic f, input logic [63:0] x);
  logic [62:0] m;
  logic        s;
  int          idx;
  m = magnitude(f, x);
  s = sign_of(f, x);
  if (nan_val(f, x))
    idx = snan_val(f, x) ? CLS_SNAN : CLS_QNAN;
  else if (m == inf_mag(f))
    idx = s ? CLS_NEG_INF : CLS_POS_INF;
  else if (m == '0)
    idx = s ? CLS_NEG_ZERO : CLS_POS_ZERO;
  else if (m < norm_min(f))
    idx = s ? CLS_NEG_SUB : CLS_POS_SUB;
  else
    idx = s ? CLS_NEG_NORM : CLS_POS_NORM;
  return 64'h1 << idx;
endfunction

function automatic logic [63:0] ref_result(input fp_op_e o, input logic f,
                                           input logic [63:0] a_raw, input logic [63:0] b_raw);
  logic [63:0]        a;
  logic [63:0]        b;
  logic               an;
  logic               bn;
  logic signed [64:0] ka;
  logic signed [64:0] kb;
  a  = unbox(f, a_raw);
  b  = unbox(f, b_raw);
  an = nan_val(f, a);
  bn = nan_val(f, b);
  ka = order_key(f, a);
  kb = order_key(f, b);
  case (o)
    OP_FEQ: return {63'b0, !an && !bn && (ka == kb)};
    OP_FLT: return {63'b0, !an && !bn && (ka < kb)};
    OP_FLE: return {63'b0, !an && !bn && (ka <= kb)};
    OP_FMIN, OP_FMAX: begin
      if (an && bn)
        return f ? CANON_NAN_D : {32'hFFFF_FFFF, CANON_NAN_S};
      if (an)
        return b;
      if (bn)
        return a;
      if (ka == kb)  // Mixed zeros, min takes the negative one
        return ((o == OP_FMIN) == sign_of(f, a)) ? a : b;
      return ((ka < kb) == (o == OP_FMIN)) ? a : b;
    end
    OP_FCLASS: return class_mask(f, a);
    default: return '0;
  endcase
endfunction

function automatic logic ref_nv(input fp_op_e o, input logic f,
                                input logic [63:0] a_raw, input logic [63:0] b_raw);
  logic [63:0] a;
  logic [63:0] b;
  a = unbox(f, a_raw);
  b = unbox(f, b_raw);
  case (o)
    OP_FEQ, OP_FMIN, OP_FMAX: return snan_val(f, a) || snan_val(f, b);
    OP_FLT, OP_FLE:           return nan_val(f, a) || nan_val(f, b);  // Signaling compares
    default:                  return 1'b0;
  endcase
endfunction

`endif

//--- testbench/tb_fp_cmp_unit.sv
/*
  Testbench for the FP compare/classify unit
  Random and directed compare, min/max and classify traffic against a reference model
*/
`timescale 1ns/1ps

module tb_fp_cmp_unit import fp_cmp_pkg::*; ();

  localparam int FLEN         = 64;
  localparam int CLK_PERIOD   = 40;
  localparam int RST_CYCLES   = 5;
  localparam int NUM_RAND     = 300;  // Random pairs, three compares each
  localparam int NUM_DIRECTED = 100;  // Upper bound on directed operations
  localparam int TIMEOUT_NS   = (RST_CYCLES + 3 * NUM_RAND + NUM_DIRECTED + 200) * CLK_PERIOD;

  // One value per class in FCLASS bit order
  localparam logic [31:0] S_CLASS [10] = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001,
    32'h8000_0000, 32'h0000_0000, 32'h0000_0001, 32'h3F80_0000, 32'h7F80_0000,
    32'h7F80_0001, 32'h7FC0_0000};
  localparam logic [63:0] D_CLASS [10] = '{64'hFFF0_0000_0000_0000, 64'hBFF0_0000_0000_0000,
    64'h8000_0000_0000_0001, 64'h8000_0000_0000_0000, 64'h0, 64'h1, 64'h3FF0_0000_0000_0000,
    64'h7FF0_0000_0000_0000, 64'h7FF0_0000_0000_0001, 64'h7FF8_0000_0000_0000};

  logic            clk = 1'b0;
  logic            arst_n;
  logic            in_valid;
  fp_op_e          op;
  logic            fmt;
  logic [FLEN-1:0] operand_a;
  logic [FLEN-1:0] operand_b;
  logic            out_valid;
  logic [FLEN-1:0] result;
  logic            flag_nv;

  integer          seed = 32'h33cd;
  int              checks;
  int              value_errors;
  int              protocol_errors;
  logic [FLEN-1:0] exp_res [$];  // Expected results in issue order
  logic            exp_nv [$];
  string           exp_name [$];
  logic [FLEN-1:0] e_res;
  logic            e_nv;
  string           e_name;

  `include "tb_fp_cmp_ref.svh"

  fp_cmp_unit #(.FLEN(FLEN)) fp_cmp_unit_i (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .op(op), .fmt(fmt),
    .operand_a(operand_a), .operand_b(operand_b),
    .out_valid(out_valid), .result(result), .flag_nv(flag_nv)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Directed value of one class, boxed in single format
  function automatic logic [63:0] pick(input logic f, input int idx);
    return f ? D_CLASS[idx[3:0]] : {32'hFFFF_FFFF, S_CLASS[idx[3:0]]};
  endfunction

  // Finite nonzero normal value
  function automatic logic [63:0] rand_value(input logic f);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [10:0] e11;
    logic [7:0]  e8;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    e11 = 11'(r2[10:0] % 11'h7FE) + 11'd1;
    e8  = 8'(r2[7:0] % 8'hFE) + 8'd1;
    if (f)
      return {r2[31], e11, r0[19:0], r1};
    return {32'hFFFF_FFFF, r2[31], e8, r1[22:0]};
  endfunction

  // Second operand, often equal or close to the first
  function automatic logic [63:0] partner(input logic f, input logic [63:0] a);
    logic [31:0] r;
    r = $random(seed);
    case (r[1:0])
      2'd0:    return a;
      2'd1:    return f ? {~a[63], a[62:0]} : {a[63:32], ~a[31], a[30:0]};  // Sign flipped
      2'd2:    return {a[63:20], r[31:12]};  // Same exponent and box
      default: return rand_value(f);
    endcase
  endfunction

  task automatic issue(input string name, input fp_op_e o, input logic f,
                       input logic [63:0] a, input logic [63:0] b);
    @(posedge clk);
    in_valid  <= 1'b1;
    op        <= o;
    fmt       <= f;
    operand_a <= a;
    operand_b <= b;
    exp_res.push_back(ref_result(o, f, a, b));
    exp_nv.push_back(ref_nv(o, f, a, b));
    exp_name.push_back(name);
  endtask

  task automatic idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic compare3(input string name, input logic f, input logic [63:0] a,
                          input logic [63:0] b);
    issue({name, " feq"}, OP_FEQ, f, a, b);
    issue({name, " flt"}, OP_FLT, f, a, b);
    issue({name, " fle"}, OP_FLE, f, a, b);
  endtask

  task automatic minmax2(input string name, input logic f, input logic [63:0] a,
                         input logic [63:0] b);
    issue({name, " fmin"}, OP_FMIN, f, a, b);
    issue({name, " fmax"}, OP_FMAX, f, a, b);
  endtask

  initial begin
    logic [63:0] a;
    logic [31:0] r;
    logic        f;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    op        = OP_FEQ;
    fmt       = 1'b0;
    operand_a = '0;
    operand_b = '0;
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    idle();

    for (int i = 0; i < NUM_RAND; i++) begin
      r = $random(seed);
      f = r[0];  // Format per pair
      a = rand_value(f);
      compare3("random", f, a, partner(f, a));
    end
    idle();

    for (int k = 0; k < 2; k++) begin
      f = k[0];
      compare3("zeros", f, pick(f, CLS_POS_ZERO), pick(f, CLS_NEG_ZERO));
      compare3("zeros", f, pick(f, CLS_NEG_ZERO), pick(f, CLS_POS_ZERO));
      compare3("qnan", f, pick(f, CLS_QNAN), pick(f, CLS_POS_NORM));
      compare3("snan", f, pick(f, CLS_POS_NORM), pick(f, CLS_SNAN));
      minmax2("ordinary", f, pick(f, CLS_POS_NORM), pick(f, CLS_NEG_NORM));
      minmax2("ordinary", f, pick(f, CLS_POS_SUB), pick(f, CLS_POS_INF));
      minmax2("one nan", f, pick(f, CLS_QNAN), pick(f, CLS_POS_NORM));
      minmax2("one nan", f, pick(f, CLS_NEG_INF), pick(f, CLS_QNAN));
      minmax2("two nan", f, pick(f, CLS_QNAN), pick(f, CLS_SNAN));
      minmax2("mixed zero", f, pick(f, CLS_POS_ZERO), pick(f, CLS_NEG_ZERO));
      minmax2("mixed zero", f, pick(f, CLS_NEG_ZERO), pick(f, CLS_POS_ZERO));
      minmax2("snan", f, pick(f, CLS_SNAN), pick(f, CLS_NEG_NORM));
      for (int c = 0; c < FCLASS_W; c++)
        issue("fclass", OP_FCLASS, f, pick(f, c), '0);
      idle();
    end

    // Upper half not all ones, single format
    a = 64'h0000_0000_3F80_0000;
    compare3("bad box", 1'b0, a, pick(1'b0, CLS_POS_NORM));
    minmax2("bad box", 1'b0, a, pick(1'b0, CLS_NEG_NORM));
    minmax2("bad box pair", 1'b0, a, 64'h1234_5678_0000_0000);
    issue("bad box fclass", OP_FCLASS, 1'b0, a, '0);
    issue("reserved op", fp_op_e'(3'd6), 1'b1, pick(1'b1, CLS_POS_NORM), '0);
    idle();

    while (exp_res.size() != 0)
      @(posedge clk);
    repeat (3) @(posedge clk);  // Catch stray outputs
    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             checks, value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // Compares each output against the oldest expected pair
  always @(posedge clk) begin
    if (arst_n && out_valid) begin
      if (exp_res.size() == 0) begin
        $display("Output valid at %0t with no operation outstanding", $time);
        protocol_errors++;
      end else begin
        e_res  = exp_res.pop_front();
        e_nv   = exp_nv.pop_front();
        e_name = exp_name.pop_front();
        checks++;
        if (result !== e_res) begin
          $display("ERR %s result: expected %h actual %h", e_name, e_res, result);
          value_errors++;
        end
        if (flag_nv !== e_nv) begin
          $display("ERR %s nv: expected %0b actual %0b", e_name, e_nv, flag_nv);
          value_errors++;
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- all.f
+incdir+testbench
hdl/fp_cmp_pkg.sv
hdl/fp_unpack.sv
hdl/fp_compare.sv
hdl/fp_minmax.sv
hdl/fp_classify.sv
hdl/fp_cmp_unit.sv
testbench/fp_cmp_unit_sva.sv
testbench/tb_fp_cmp_unit.sv

//--- Makefile
# Verilator build and run of the FP compare/classify unit testbench

VERILATOR ?= verilator
TOP       ?= tb_fp_cmp_unit
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
